/* hw/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb; // one bit per byte lane.
  } axi_w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
  } axi_r_t;

  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

  // master side of one port.
  typedef struct packed {
    logic    ar_valid;
    axi_ar_t ar;
    logic    r_ready;
    logic    aw_valid;
    axi_aw_t aw;
    logic    w_valid;
    axi_w_t  w;
    logic    b_ready;
  } axi_req_t;

  typedef struct packed {
    logic   ar_ready;
    logic   r_valid;
    axi_r_t r;
    logic   aw_ready;
    logic   w_ready;
    logic   b_valid;
    axi_b_t b;
  } axi_rsp_t;

endpackage

`default_nettype wire

/* hw/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

  localparam logic [31:0] SRAM_BASE      = 32'h8000_0000; // decoded on bits 31:27.
  localparam logic [31:0] CLINT_MTIME_LO = 32'ha000_0048;
  localparam logic [31:0] CLINT_MTIME_HI = 32'ha000_004c;
  localparam logic [31:0] UART_TX_ADDR   = 32'ha000_03f8;

  typedef enum logic [1:0] {
    DEV_NONE,
    DEV_SRAM,
    DEV_CLINT,
    DEV_UART
  } dev_e;

endpackage

`default_nettype wire

/* hw/sram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_slave #(
  parameter int SRAM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rstn,
  input  axi_pkg::axi_req_t req,
  output axi_pkg::axi_rsp_t rsp
);

  localparam int IDX_W = $clog2(SRAM_WORDS);

  logic [axi_pkg::DATA_W-1:0] mem [SRAM_WORDS];
  logic [axi_pkg::DATA_W-1:0] r_data;
  logic [IDX_W-1:0]           aw_idx;
  logic [IDX_W-1:0]           wr_idx;
  axi_pkg::axi_w_t            w_q;
  axi_pkg::axi_w_t            wr_w;
  logic                       r_valid;
  logic                       b_valid;
  logic                       aw_got;
  logic                       w_got;
  logic                       ar_hs;
  logic                       aw_hs;
  logic                       w_hs;
  logic                       wr_fire;

  always_comb begin
    rsp          = '0;
    rsp.ar_ready = !r_valid;
    rsp.r_valid  = r_valid;
    rsp.r.data   = r_data;
    rsp.r.resp   = axi_pkg::RESP_OKAY;
    rsp.aw_ready = !aw_got && !b_valid;
    rsp.w_ready  = !w_got && !b_valid;
    rsp.b_valid  = b_valid;
    rsp.b.resp   = axi_pkg::RESP_OKAY;
  end

  assign ar_hs   = req.ar_valid && rsp.ar_ready;
  assign aw_hs   = req.aw_valid && rsp.aw_ready;
  assign w_hs    = req.w_valid && rsp.w_ready;
  assign wr_fire = (aw_got || aw_hs) && (w_got || w_hs) && !b_valid;
  assign wr_idx  = aw_got ? aw_idx : req.aw.addr[IDX_W+1:2]; // word index, wraps.
  assign wr_w    = w_got ? w_q : req.w;

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_data <= mem[req.ar.addr[IDX_W+1:2]];
    end
    if (aw_hs) begin
      aw_idx <= req.aw.addr[IDX_W+1:2];
    end
    if (w_hs) begin
      w_q <= req.w;
    end
    if (wr_fire) begin
      for (int i = 0; i < axi_pkg::DATA_W / 8; i++) begin
        if (wr_w.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= wr_w.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
    end else begin
      if (ar_hs) begin
        r_valid <= 1'b1;
      end else if (req.r_ready) begin
        r_valid <= 1'b0;
      end
      if (wr_fire) begin
        aw_got  <= 1'b0;
        w_got   <= 1'b0;
        b_valid <= 1'b1;
      end else begin
        if (aw_hs) begin
          aw_got <= 1'b1;
        end
        if (w_hs) begin
          w_got <= 1'b1;
        end
        if (req.b_ready) begin
          b_valid <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/clint_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_slave (
  input  logic              clk,
  input  logic              rstn,
  input  axi_pkg::axi_req_t req,
  output axi_pkg::axi_rsp_t rsp
);

  logic [63:0]                mtime;
  logic [axi_pkg::DATA_W-1:0] r_data;
  logic                       r_valid;
  logic                       ar_hs;

  // write channels stay closed.
  always_comb begin
    rsp          = '0;
    rsp.ar_ready = !r_valid;
    rsp.r_valid  = r_valid;
    rsp.r.data   = r_data;
    rsp.r.resp   = axi_pkg::RESP_OKAY;
  end

  assign ar_hs = req.ar_valid && rsp.ar_ready;

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_data <= req.ar.addr[2] ? mtime[63:32] : mtime[31:0]; // bit 2 picks the half.
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      mtime   <= '0;
      r_valid <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (ar_hs) begin
        r_valid <= 1'b1;
      end else if (req.r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/uart_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_slave (
  input  logic              clk,
  input  logic              rstn,
  input  axi_pkg::axi_req_t req,
  output axi_pkg::axi_rsp_t rsp,
  output logic              tx_valid,
  output logic [7:0]        tx_data
);

  logic [7:0] w_byte;
  logic       aw_got;
  logic       w_got;
  logic       b_valid;
  logic       aw_hs;
  logic       w_hs;
  logic       fire;

  always_comb begin
    rsp          = '0;
    rsp.aw_ready = !aw_got && !b_valid;
    rsp.w_ready  = !w_got && !b_valid;
    rsp.b_valid  = b_valid;
    rsp.b.resp   = axi_pkg::RESP_OKAY;
  end

  assign aw_hs = req.aw_valid && rsp.aw_ready;
  assign w_hs  = req.w_valid && rsp.w_ready;
  assign fire  = (aw_got || aw_hs) && (w_got || w_hs) && !b_valid;

  always_ff @(posedge clk) begin
    if (w_hs) begin
      w_byte <= req.w.data[7:0];
    end
    if (fire) begin
      tx_data <= w_got ? w_byte : req.w.data[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      b_valid  <= 1'b0;
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= fire; // single cycle strobe.
      if (fire) begin
        aw_got  <= 1'b0;
        w_got   <= 1'b0;
        b_valid <= 1'b1;
      end else begin
        if (aw_hs) begin
          aw_got <= 1'b1;
        end
        if (w_hs) begin
          w_got <= 1'b1;
        end
        if (req.b_ready) begin
          b_valid <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/axi_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter (
  input  logic              clk,
  input  logic              rstn,
  input  axi_pkg::axi_req_t s0_req,
  input  axi_pkg::axi_req_t s1_req,
  output axi_pkg::axi_rsp_t s0_rsp,
  output axi_pkg::axi_rsp_t s1_rsp,
  output axi_pkg::axi_req_t m_req,
  input  axi_pkg::axi_rsp_t m_rsp
);

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_e;

  arb_state_e        state;
  logic              live;   // high once out of reset.
  logic              owner;
  logic              dir_wr;
  logic              ptr;
  logic              ptr_has_addr;
  logic              sel;
  logic              idle;
  logic              en_ar;
  logic              en_aw;
  logic              en_w;
  logic              en_r;
  logic              en_b;
  axi_pkg::axi_req_t cur;
  axi_pkg::axi_rsp_t grant_rsp;

  assign idle         = live && (state == ARB_IDLE);
  assign ptr_has_addr = ptr ? (s1_req.ar_valid || s1_req.aw_valid)
                            : (s0_req.ar_valid || s0_req.aw_valid);
  assign sel = (state == ARB_BUSY) ? owner : (ptr_has_addr ? ptr : ~ptr);
  assign cur = sel ? s1_req : s0_req;

  // a read wins if the chosen master offers both.
  assign en_ar = idle;
  assign en_aw = idle && !cur.ar_valid;
  assign en_w  = idle ? (cur.aw_valid && !cur.ar_valid) : ((state == ARB_BUSY) && dir_wr);
  assign en_r  = (state == ARB_BUSY) && !dir_wr;
  assign en_b  = (state == ARB_BUSY) && dir_wr;

  always_comb begin
    m_req          = cur;
    m_req.ar_valid = cur.ar_valid && en_ar;
    m_req.aw_valid = cur.aw_valid && en_aw;
    m_req.w_valid  = cur.w_valid && en_w;
    m_req.r_ready  = cur.r_ready && en_r;
    m_req.b_ready  = cur.b_ready && en_b;
  end

  always_comb begin
    grant_rsp          = m_rsp;
    grant_rsp.ar_ready = m_rsp.ar_ready && en_ar;
    grant_rsp.aw_ready = m_rsp.aw_ready && en_aw;
    grant_rsp.w_ready  = m_rsp.w_ready && en_w;
    grant_rsp.r_valid  = m_rsp.r_valid && en_r;
    grant_rsp.b_valid  = m_rsp.b_valid && en_b;
    s0_rsp = '0;
    s1_rsp = '0;
    if (sel) begin
      s1_rsp = grant_rsp;
    end else begin
      s0_rsp = grant_rsp;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      state  <= ARB_IDLE;
      live   <= 1'b0;
      owner  <= 1'b0;
      dir_wr <= 1'b0;
      ptr    <= 1'b0;
    end else begin
      live <= 1'b1;
      case (state)
        ARB_IDLE: begin
          if (m_req.ar_valid && m_rsp.ar_ready) begin
            state  <= ARB_BUSY;
            owner  <= sel;
            dir_wr <= 1'b0;
          end else if (m_req.aw_valid && m_rsp.aw_ready) begin
            state  <= ARB_BUSY;
            owner  <= sel;
            dir_wr <= 1'b1;
          end
        end
        ARB_BUSY: begin
          if ((m_req.r_ready && m_rsp.r_valid) || (m_req.b_ready && m_rsp.b_valid)) begin
            state <= ARB_IDLE;
            ptr   <= ~owner; // other master first next time.
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/axi_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_xbar (
  input  logic              clk,
  input  logic              rstn,
  input  axi_pkg::axi_req_t s_req,
  output axi_pkg::axi_rsp_t s_rsp,
  output axi_pkg::axi_req_t sram_req,
  output axi_pkg::axi_req_t clint_req,
  output axi_pkg::axi_req_t uart_req,
  input  axi_pkg::axi_rsp_t sram_rsp,
  input  axi_pkg::axi_rsp_t clint_rsp,
  input  axi_pkg::axi_rsp_t uart_rsp
);

  soc_map_pkg::dev_e rd_dec;
  soc_map_pkg::dev_e wr_dec;
  soc_map_pkg::dev_e rd_sel;
  soc_map_pkg::dev_e wr_addr_sel;
  soc_map_pkg::dev_e wr_sel;
  soc_map_pkg::dev_e rd_dev;
  soc_map_pkg::dev_e wr_dev;
  logic              rd_active;
  logic              wr_active;
  logic              busy;
  logic              ar_hs;
  logic              aw_hs;
  logic              w_hs;
  logic              r_hs;
  logic              b_hs;
  logic              err_wr;
  logic              err_r_valid;
  logic              err_w_got;
  logic              err_b_valid;

  function automatic soc_map_pkg::dev_e decode(input logic [axi_pkg::ADDR_W-1:0] addr);
    soc_map_pkg::dev_e dev;
    dev = soc_map_pkg::DEV_NONE;
    if (addr[31:27] == soc_map_pkg::SRAM_BASE[31:27]) begin
      dev = soc_map_pkg::DEV_SRAM;
    end else if (addr == soc_map_pkg::CLINT_MTIME_LO || addr == soc_map_pkg::CLINT_MTIME_HI) begin
      dev = soc_map_pkg::DEV_CLINT;
    end else if (addr == soc_map_pkg::UART_TX_ADDR) begin
      dev = soc_map_pkg::DEV_UART;
    end
    return dev;
  endfunction

  // payloads go everywhere, handshakes are added per route.
  function automatic axi_pkg::axi_req_t payload_only(input axi_pkg::axi_req_t req);
    axi_pkg::axi_req_t res;
    res          = req;
    res.ar_valid = 1'b0;
    res.r_ready  = 1'b0;
    res.aw_valid = 1'b0;
    res.w_valid  = 1'b0;
    res.b_ready  = 1'b0;
    return res;
  endfunction

  assign rd_dec = decode(s_req.ar.addr);
  assign wr_dec = decode(s_req.aw.addr);

  // reads reach sram and clint, writes reach sram and uart.
  assign rd_sel = (rd_dec == soc_map_pkg::DEV_SRAM || rd_dec == soc_map_pkg::DEV_CLINT)
                ? rd_dec : soc_map_pkg::DEV_NONE;
  assign wr_addr_sel = (wr_dec == soc_map_pkg::DEV_SRAM || wr_dec == soc_map_pkg::DEV_UART)
                     ? wr_dec : soc_map_pkg::DEV_NONE;
  assign wr_sel = wr_active ? wr_dev : wr_addr_sel;

  assign busy   = rd_active || wr_active;
  assign ar_hs  = s_req.ar_valid && s_rsp.ar_ready;
  assign aw_hs  = s_req.aw_valid && s_rsp.aw_ready;
  assign w_hs   = s_req.w_valid && s_rsp.w_ready;
  assign r_hs   = s_rsp.r_valid && s_req.r_ready;
  assign b_hs   = s_rsp.b_valid && s_req.b_ready;
  assign err_wr = (wr_sel == soc_map_pkg::DEV_NONE) && (wr_active || !busy);

  always_comb begin
    sram_req  = payload_only(s_req);
    clint_req = payload_only(s_req);
    uart_req  = payload_only(s_req);
    s_rsp     = '0;
    if (!busy) begin
      case (rd_sel)
        soc_map_pkg::DEV_SRAM: begin
          sram_req.ar_valid = s_req.ar_valid;
          s_rsp.ar_ready    = sram_rsp.ar_ready;
        end
        soc_map_pkg::DEV_CLINT: begin
          clint_req.ar_valid = s_req.ar_valid;
          s_rsp.ar_ready     = clint_rsp.ar_ready;
        end
        default: s_rsp.ar_ready = 1'b1; // error path takes it at once.
      endcase
      case (wr_addr_sel)
        soc_map_pkg::DEV_SRAM: begin
          sram_req.aw_valid = s_req.aw_valid;
          s_rsp.aw_ready    = sram_rsp.aw_ready;
        end
        soc_map_pkg::DEV_UART: begin
          uart_req.aw_valid = s_req.aw_valid;
          s_rsp.aw_ready    = uart_rsp.aw_ready;
        end
        default: s_rsp.aw_ready = 1'b1;
      endcase
    end
    if (wr_active || !busy) begin
      case (wr_sel)
        soc_map_pkg::DEV_SRAM: begin
          sram_req.w_valid = s_req.w_valid;
          s_rsp.w_ready    = sram_rsp.w_ready;
        end
        soc_map_pkg::DEV_UART: begin
          uart_req.w_valid = s_req.w_valid;
          s_rsp.w_ready    = uart_rsp.w_ready;
        end
        default: s_rsp.w_ready = !err_w_got && !err_b_valid;
      endcase
    end
    if (rd_active) begin
      case (rd_dev)
        soc_map_pkg::DEV_SRAM: begin
          sram_req.r_ready = s_req.r_ready;
          s_rsp.r_valid    = sram_rsp.r_valid;
          s_rsp.r          = sram_rsp.r;
        end
        soc_map_pkg::DEV_CLINT: begin
          clint_req.r_ready = s_req.r_ready;
          s_rsp.r_valid     = clint_rsp.r_valid;
          s_rsp.r           = clint_rsp.r;
        end
        default: begin
          s_rsp.r_valid = err_r_valid;
          s_rsp.r.resp  = axi_pkg::RESP_DECERR; // data stays zero.
        end
      endcase
    end
    if (wr_active) begin
      case (wr_dev)
        soc_map_pkg::DEV_SRAM: begin
          sram_req.b_ready = s_req.b_ready;
          s_rsp.b_valid    = sram_rsp.b_valid;
          s_rsp.b          = sram_rsp.b;
        end
        soc_map_pkg::DEV_UART: begin
          uart_req.b_ready = s_req.b_ready;
          s_rsp.b_valid    = uart_rsp.b_valid;
          s_rsp.b          = uart_rsp.b;
        end
        default: begin
          s_rsp.b_valid = err_b_valid;
          s_rsp.b.resp  = axi_pkg::RESP_DECERR;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_active   <= 1'b0;
      wr_active   <= 1'b0;
      rd_dev      <= soc_map_pkg::DEV_NONE;
      wr_dev      <= soc_map_pkg::DEV_NONE;
      err_r_valid <= 1'b0;
      err_w_got   <= 1'b0;
      err_b_valid <= 1'b0;
    end else begin
      if (ar_hs) begin
        rd_active   <= 1'b1;
        rd_dev      <= rd_sel;
        err_r_valid <= (rd_sel == soc_map_pkg::DEV_NONE);
      end else if (r_hs) begin
        rd_active   <= 1'b0;
        err_r_valid <= 1'b0;
      end
      if (aw_hs) begin
        wr_active <= 1'b1;
        wr_dev    <= wr_addr_sel;
      end else if (b_hs) begin
        wr_active <= 1'b0;
      end
      if (b_hs) begin
        err_w_got   <= 1'b0;
        err_b_valid <= 1'b0;
      end else if (err_wr) begin
        if (w_hs) begin
          err_w_got <= 1'b1;
        end
        if ((wr_active || aw_hs) && (err_w_got || w_hs)) begin
          err_b_valid <= 1'b1; // both halves seen.
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/mem_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
  parameter int SRAM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rstn,
  input  axi_pkg::axi_req_t m0_req,
  input  axi_pkg::axi_req_t m1_req,
  output axi_pkg::axi_rsp_t m0_rsp,
  output axi_pkg::axi_rsp_t m1_rsp,
  output logic              tx_valid,
  output logic [7:0]        tx_data
);

  axi_pkg::axi_req_t bus_req;
  axi_pkg::axi_rsp_t bus_rsp;
  axi_pkg::axi_req_t sram_req;
  axi_pkg::axi_rsp_t sram_rsp;
  axi_pkg::axi_req_t clint_req;
  axi_pkg::axi_rsp_t clint_rsp;
  axi_pkg::axi_req_t uart_req;
  axi_pkg::axi_rsp_t uart_rsp;

  axi_arbiter axi_arbiter_inst (
    .clk    (clk),
    .rstn   (rstn),
    .s0_req (m0_req), // instruction fetch.
    .s1_req (m1_req), // load/store.
    .s0_rsp (m0_rsp),
    .s1_rsp (m1_rsp),
    .m_req  (bus_req),
    .m_rsp  (bus_rsp)
  );

  axi_xbar axi_xbar_inst (
    .clk       (clk),
    .rstn      (rstn),
    .s_req     (bus_req),
    .s_rsp     (bus_rsp),
    .sram_req  (sram_req),
    .clint_req (clint_req),
    .uart_req  (uart_req),
    .sram_rsp  (sram_rsp),
    .clint_rsp (clint_rsp),
    .uart_rsp  (uart_rsp)
  );

  sram_slave #(
    .SRAM_WORDS (SRAM_WORDS)
  ) sram_slave_inst (
    .clk  (clk),
    .rstn (rstn),
    .req  (sram_req),
    .rsp  (sram_rsp)
  );

  clint_slave clint_slave_inst (
    .clk  (clk),
    .rstn (rstn),
    .req  (clint_req),
    .rsp  (clint_rsp)
  );

  uart_slave uart_slave_inst (
    .clk      (clk),
    .rstn     (rstn),
    .req      (uart_req),
    .rsp      (uart_rsp),
    .tx_valid (tx_valid),
    .tx_data  (tx_data)
  );

endmodule

`default_nettype wire

/* verification/mem_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

  localparam int SRAM_WORDS = 256;
  localparam int TIMEOUT    = 50;
  localparam int NAME_W     = 8 * 20;

  typedef enum logic {
    OP_RD,
    OP_WR
  } op_e;

  typedef struct packed {
    logic               master;
    op_e                op;
    logic [31:0]        addr;
    logic [31:0]        data;
    logic [3:0]         strb;
    logic [31:0]        exp_data;
    axi_pkg::axi_resp_e exp_resp;
    logic [NAME_W-1:0]  name;
  } vec_t;

  logic              clk;
  logic              rstn;
  axi_pkg::axi_req_t mreq [2];
  axi_pkg::axi_rsp_t mrsp [2];
  logic              tx_valid;
  logic [7:0]        tx_data;

  vec_t        vec_q [$];
  logic [31:0] sram_model [SRAM_WORDS];
  logic        done_q [$];
  logic        last_master = 1'b1; // pointer starts at master 0.
  int unsigned cycle_cnt = 0;
  int          err_cnt = 0;
  int          to_cnt = 0;
  int          tx_cnt = 0;
  logic [7:0]  tx_last = '0;

  mem_subsys_top #(
    .SRAM_WORDS (SRAM_WORDS)
  ) mem_subsys_top_inst (
    .clk      (clk),
    .rstn     (rstn),
    .m0_req   (mreq[0]),
    .m1_req   (mreq[1]),
    .m0_rsp   (mrsp[0]),
    .m1_rsp   (mrsp[1]),
    .tx_valid (tx_valid),
    .tx_data  (tx_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // count uart strobes between edges.
  always @(negedge clk) begin
    if (tx_valid === 1'b1) begin
      tx_cnt  = tx_cnt + 1;
      tx_last = tx_data;
    end
  end

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % SRAM_WORDS);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic void add_vec(input logic m, input op_e op, input logic [31:0] addr,
                                  input logic [31:0] data, input logic [3:0] strb,
                                  input logic [31:0] exp_data,
                                  input axi_pkg::axi_resp_e exp_resp,
                                  input logic [NAME_W-1:0] name);
    vec_t v;
    v.master   = m;
    v.op       = op;
    v.addr     = addr;
    v.data     = data;
    v.strb     = strb;
    v.exp_data = exp_data;
    v.exp_resp = exp_resp;
    v.name     = name;
    vec_q.push_back(v);
  endfunction

  function automatic void add_sram_write(input logic m, input logic [31:0] addr,
                                         input logic [3:0] strb,
                                         input logic [NAME_W-1:0] name);
    logic [31:0] data;
    data = $urandom;
    sram_model[word_index(addr)] = merge_bytes(sram_model[word_index(addr)], data, strb);
    add_vec(m, OP_WR, addr, data, strb, 32'h0, axi_pkg::RESP_OKAY, name);
  endfunction

  function automatic void add_sram_read(input logic m, input logic [31:0] addr,
                                        input logic [NAME_W-1:0] name);
    add_vec(m, OP_RD, addr, 32'h0, 4'h0, sram_model[word_index(addr)],
            axi_pkg::RESP_OKAY, name);
  endfunction

  task automatic check_value(input logic [NAME_W-1:0] name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    assert (exp_val === act_val) else begin
      $display("[FAIL] %0s: expected %0h, actual %0h", name, exp_val, act_val);
      err_cnt++;
    end
  endtask

  task automatic read_xact(input int m, input logic [31:0] addr, output logic [31:0] data,
                           output axi_pkg::axi_resp_e resp, output int unsigned ar_cyc);
    int   cnt;
    logic hit;
    data   = '0;
    resp   = axi_pkg::RESP_SLVERR;
    ar_cyc = 0;
    @(posedge clk);
    mreq[m].ar_valid <= 1'b1;
    mreq[m].ar.addr  <= addr;
    cnt = 0;
    hit = 1'b0;
    while (!hit && cnt < TIMEOUT) begin
      @(negedge clk);
      hit    = mrsp[m].ar_ready;
      ar_cyc = cycle_cnt;
      cnt++;
    end
    @(posedge clk);
    mreq[m].ar_valid <= 1'b0;
    if (!hit) begin
      $display("timeout: master %0d read address channel was never accepted", m);
      to_cnt++;
      return;
    end
    mreq[m].r_ready <= 1'b1;
    cnt = 0;
    hit = 1'b0;
    while (!hit && cnt < TIMEOUT) begin
      @(negedge clk);
      hit  = mrsp[m].r_valid;
      data = mrsp[m].r.data;
      resp = mrsp[m].r.resp;
      cnt++;
    end
    @(posedge clk);
    mreq[m].r_ready <= 1'b0;
    if (!hit) begin
      $display("timeout: master %0d read data channel never became valid", m);
      to_cnt++;
      return;
    end
    done_q.push_back(m[0]);
    last_master = m[0];
  endtask

  task automatic write_xact(input int m, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output axi_pkg::axi_resp_e resp);
    int   cnt;
    logic aw_pend;
    logic w_pend;
    logic aw_hit;
    logic w_hit;
    logic hit;
    resp = axi_pkg::RESP_SLVERR;
    @(posedge clk);
    mreq[m].aw_valid <= 1'b1;
    mreq[m].aw.addr  <= addr;
    mreq[m].w_valid  <= 1'b1;
    mreq[m].w.data   <= data;
    mreq[m].w.strb   <= strb;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    cnt     = 0;
    while ((aw_pend || w_pend) && cnt < TIMEOUT) begin
      @(negedge clk);
      aw_hit = aw_pend && mrsp[m].aw_ready;
      w_hit  = w_pend && mrsp[m].w_ready;
      cnt++;
      @(posedge clk);
      if (aw_hit) begin
        mreq[m].aw_valid <= 1'b0;
        aw_pend = 1'b0;
      end
      if (w_hit) begin
        mreq[m].w_valid <= 1'b0;
        w_pend = 1'b0;
      end
    end
    if (aw_pend || w_pend) begin
      mreq[m].aw_valid <= 1'b0;
      mreq[m].w_valid  <= 1'b0;
      $display("timeout: master %0d write address or data channel was never accepted", m);
      to_cnt++;
      return;
    end
    mreq[m].b_ready <= 1'b1;
    cnt = 0;
    hit = 1'b0;
    while (!hit && cnt < TIMEOUT) begin
      @(negedge clk);
      hit  = mrsp[m].b_valid;
      resp = mrsp[m].b.resp;
      cnt++;
    end
    @(posedge clk);
    mreq[m].b_ready <= 1'b0;
    if (!hit) begin
      $display("timeout: master %0d write response channel never became valid", m);
      to_cnt++;
      return;
    end
    last_master = m[0];
  endtask

  task automatic check_mtime_rising();
    logic [31:0]        lo1;
    logic [31:0]        lo2;
    axi_pkg::axi_resp_e resp;
    int unsigned        c1;
    int unsigned        c2;
    read_xact(0, soc_map_pkg::CLINT_MTIME_LO, lo1, resp, c1);
    check_value("mtime_lo_first", axi_pkg::RESP_OKAY, resp);
    repeat (5) @(posedge clk);
    read_xact(0, soc_map_pkg::CLINT_MTIME_LO, lo2, resp, c2);
    check_value("mtime_lo_second", axi_pkg::RESP_OKAY, resp);
    assert (lo2 > lo1) else begin
      $display("[FAIL] mtime_lo_rising: expected above %0h, actual %0h", lo1, lo2);
      err_cnt++;
    end
    assert ((lo2 - lo1) >= (c2 - c1)) else begin
      $display("[FAIL] mtime_lo_delta: expected at least %0d, actual %0d", c2 - c1, lo2 - lo1);
      err_cnt++;
    end
  endtask

  task automatic check_uart_tx(input logic [31:0] data);
    axi_pkg::axi_resp_e resp;
    int                 cnt_before;
    cnt_before = tx_cnt;
    write_xact(0, soc_map_pkg::UART_TX_ADDR, data, 4'hf, resp);
    check_value("uart_wr_resp", axi_pkg::RESP_OKAY, resp);
    repeat (3) @(posedge clk); // a second strobe would show here.
    check_value("uart_tx_pulses", 1, tx_cnt - cnt_before);
    check_value("uart_tx_data", data[7:0], tx_last);
  endtask

  task automatic contested_reads(input logic [31:0] addr0, input logic [31:0] addr1,
                                 input logic [NAME_W-1:0] name);
    logic [31:0]        d0;
    logic [31:0]        d1;
    axi_pkg::axi_resp_e r0;
    axi_pkg::axi_resp_e r1;
    int unsigned        c0;
    int unsigned        c1;
    logic               first;
    logic               second;
    first  = ~last_master;
    second = last_master;
    done_q.delete();
    fork
      read_xact(0, addr0, d0, r0, c0);
      read_xact(1, addr1, d1, r1, c1);
    join
    check_value(name, sram_model[word_index(addr0)], d0);
    check_value(name, sram_model[word_index(addr1)], d1);
    check_value(name, axi_pkg::RESP_OKAY, r0);
    check_value(name, axi_pkg::RESP_OKAY, r1);
    assert (done_q.size() == 2) else begin
      $display("%0s: not both contested reads completed", name);
      err_cnt++;
    end
    if (done_q.size() == 2) begin
      check_value(name, first, done_q[0]);
      check_value(name, second, done_q[1]);
    end
  endtask

  initial begin
    logic [31:0]        got;
    axi_pkg::axi_resp_e resp;
    int unsigned        cyc;
    vec_t               v;
    void'($urandom(6952));
    rstn    = 1'b1;
    mreq[0] = '0;
    mreq[1] = '0;

    add_vec(0, OP_RD, soc_map_pkg::CLINT_MTIME_HI, 32'h0, 4'h0, 32'h0,
            axi_pkg::RESP_OKAY, "mtime_hi_reset");
    add_sram_write(1, soc_map_pkg::SRAM_BASE + 32'h10, 4'hf, "sram_wr_full");
    add_sram_read(1, soc_map_pkg::SRAM_BASE + 32'h10, "sram_rd_full");
    add_sram_write(1, soc_map_pkg::SRAM_BASE + 32'h10, 4'b0101, "sram_wr_part");
    add_sram_read(1, soc_map_pkg::SRAM_BASE + 32'h10, "sram_rd_merge");
    add_sram_write(0, soc_map_pkg::SRAM_BASE + 32'h20, 4'hf, "m0_wr");
    add_sram_write(1, soc_map_pkg::SRAM_BASE + 32'h24, 4'hf, "m1_wr");
    add_sram_read(0, soc_map_pkg::SRAM_BASE + 32'h24, "m0_rd_m1_word");
    add_sram_read(1, soc_map_pkg::SRAM_BASE + 32'h20, "m1_rd_m0_word");
    add_sram_read(0, soc_map_pkg::SRAM_BASE + 4 * SRAM_WORDS + 32'h20, "sram_rd_wrap");
    add_vec(1, OP_RD, 32'h1000_0000, 32'h0, 4'h0, 32'h0, axi_pkg::RESP_DECERR, "unmapped_rd");
    add_vec(0, OP_RD, soc_map_pkg::UART_TX_ADDR, 32'h0, 4'h0, 32'h0,
            axi_pkg::RESP_DECERR, "uart_rd");
    add_vec(1, OP_WR, soc_map_pkg::CLINT_MTIME_LO, 32'h5555_aaaa, 4'hf, 32'h0,
            axi_pkg::RESP_DECERR, "clint_wr");
    add_vec(0, OP_WR, 32'h4000_0000, 32'h0bad_cafe, 4'hf, 32'h0,
            axi_pkg::RESP_DECERR, "unmapped_wr");
    add_sram_read(0, soc_map_pkg::SRAM_BASE + 32'h20, "sram_after_err");

    repeat (4) @(posedge clk);
    rstn <= 1'b0;

    foreach (vec_q[i]) begin
      v = vec_q[i];
      if (v.op == OP_RD) begin
        read_xact(v.master, v.addr, got, resp, cyc);
        check_value(v.name, v.exp_data, got);
        check_value(v.name, v.exp_resp, resp);
      end else begin
        write_xact(v.master, v.addr, v.data, v.strb, resp);
        check_value(v.name, v.exp_resp, resp);
      end
    end

    check_mtime_rising();
    check_uart_tx(32'h0000_1241);

    contested_reads(soc_map_pkg::SRAM_BASE + 32'h20, soc_map_pkg::SRAM_BASE + 32'h24,
                    "contest_first");
    read_xact(1, soc_map_pkg::SRAM_BASE + 32'h10, got, resp, cyc); // master 1 owns last.
    check_value("solo_m1_rd", sram_model[word_index(soc_map_pkg::SRAM_BASE + 32'h10)], got);
    contested_reads(soc_map_pkg::SRAM_BASE + 32'h24, soc_map_pkg::SRAM_BASE + 32'h10,
                    "contest_second");

    $display("closing: %0d value errors, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/axi_pkg.sv
hw/soc_map_pkg.sv
hw/sram_slave.sv
hw/clint_slave.sv
hw/uart_slave.sv
hw/axi_arbiter.sv
hw/axi_xbar.sv
hw/mem_subsys_top.sv
verification/mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - hw/axi_pkg.sv
  - hw/soc_map_pkg.sv
  - hw/sram_slave.sv
  - hw/clint_slave.sv
  - hw/uart_slave.sv
  - hw/axi_arbiter.sv
  - hw/axi_xbar.sv
  - hw/mem_subsys_top.sv
  - target: test
    files:
      - verification/mem_subsys_tb.sv
